/* frogger_pkg.sv */
`default_nettype none

package frogger_pkg;

    // Pixel coordinate and color widths
    localparam int COORD_W = 9;
    localparam int COLOR_W = 3;

    // Plotter resolution
    localparam int SCREEN_W = 320;
    localparam int SCREEN_H = 240;

    // Sprite tiles are square, three bits per pixel
    localparam int TILE_SIZE   = 8;
    localparam int SPRITE_ROWS = 24;

    // Sprite index, first memory row is index times TILE_SIZE
    localparam logic [1:0] SPRITE_FROG    = 2'd0;
    localparam logic [1:0] SPRITE_RIVER_1 = 2'd1;
    localparam logic [1:0] SPRITE_RIVER_2 = 2'd2;

    // River objects tile their sprite over this area
    localparam int RIVER_W = 96;
    localparam int RIVER_H = 40;

    localparam logic [COORD_W-1:0] RIVER_1_X = 9'd20;
    localparam logic [COORD_W-1:0] RIVER_1_Y = 9'd80;
    localparam logic [COORD_W-1:0] RIVER_2_X = 9'd120;
    localparam logic [COORD_W-1:0] RIVER_2_Y = 9'd150;

    // Frog is drawn at double scale
    localparam int FROG_SIZE = 16;

    // Largest allowed top-left corner of the frog
    localparam logic [COORD_W-1:0] FROG_X_MAX = COORD_W'(SCREEN_W - FROG_SIZE);
    localparam logic [COORD_W-1:0] FROG_Y_MAX = COORD_W'(SCREEN_H - FROG_SIZE);

    // Solid fills for the full-screen draws
    localparam logic [COLOR_W-1:0] COLOR_START      = 3'd4;
    localparam logic [COLOR_W-1:0] COLOR_GAME_OVER  = 3'd1;
    localparam logic [COLOR_W-1:0] COLOR_BACKGROUND = 3'd2;

    localparam string SPRITE_FILE = "sprites.mem";

    // One sprite row, either as the raw file word or as eight pixels
    // Pixel 0 is the leftmost and sits in the low bits
    typedef union packed {
        logic [TILE_SIZE*COLOR_W-1:0]      raw;
        logic [TILE_SIZE-1:0][COLOR_W-1:0] pixels;
    } pixel_row_u;

endpackage

`default_nettype wire

/* go_pulse.sv */
`timescale 1ns/1ps
`default_nettype none

module go_pulse (
    input  logic clk,
    input  logic reset,
    input  logic go_key,
    output logic go
);

    typedef enum logic [1:0] {
        S_WAIT_PRESS   = 2'd0,
        S_PULSE_1      = 2'd1,
        S_PULSE_2      = 2'd2,
        S_WAIT_RELEASE = 2'd3
    } state_t;

    state_t state;
    state_t next_state;

    always_comb begin
        case (state)
            S_WAIT_PRESS:   next_state = go_key ? S_PULSE_1 : S_WAIT_PRESS;
            S_PULSE_1:      next_state = S_PULSE_2;
            S_PULSE_2:      next_state = S_WAIT_RELEASE;
            S_WAIT_RELEASE: next_state = go_key ? S_WAIT_RELEASE : S_WAIT_PRESS;
            default:        next_state = S_WAIT_PRESS;
        endcase
    end

    // Output is registered, so go trails the pulse states by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_WAIT_PRESS;
            go    <= 1'b0;
        end else begin
            state <= next_state;
            go    <= (state == S_PULSE_1) || (state == S_PULSE_2);
        end
    end

endmodule

`default_nettype wire

/* frogger_control.sv */
`timescale 1ns/1ps
`default_nettype none

module frogger_control (
    input  logic clk,
    input  logic reset,
    input  logic go,
    input  logic scan_done,
    output logic draw_start,
    output logic draw_game_over,
    output logic draw_background,
    output logic draw_river_1,
    output logic draw_river_2,
    output logic draw_frog
);

    typedef enum logic [3:0] {
        S_WAIT_START      = 4'd0,
        S_DRAW_START      = 4'd1,
        S_WAIT_GAME_OVER  = 4'd2,
        S_DRAW_GAME_OVER  = 4'd3,
        S_WAIT_BACKGROUND = 4'd4,
        S_DRAW_BACKGROUND = 4'd5,
        S_WAIT_RIVER      = 4'd6,
        S_DRAW_RIVER_1    = 4'd7,
        S_DRAW_RIVER_2    = 4'd8,
        S_WAIT_FROG       = 4'd9,
        S_DRAW_FROG       = 4'd10
    } state_t;

    state_t state;
    state_t next_state;

    always_comb begin
        case (state)
            S_WAIT_START:      next_state = go ? S_DRAW_START : S_WAIT_START;
            S_DRAW_START:      next_state = scan_done ? S_WAIT_GAME_OVER : S_DRAW_START;
            S_WAIT_GAME_OVER:  next_state = go ? S_DRAW_GAME_OVER : S_WAIT_GAME_OVER;
            S_DRAW_GAME_OVER:  next_state = scan_done ? S_WAIT_BACKGROUND : S_DRAW_GAME_OVER;
            S_WAIT_BACKGROUND: next_state = go ? S_DRAW_BACKGROUND : S_WAIT_BACKGROUND;
            S_DRAW_BACKGROUND: next_state = scan_done ? S_WAIT_RIVER : S_DRAW_BACKGROUND;
            S_WAIT_RIVER:      next_state = go ? S_DRAW_RIVER_1 : S_WAIT_RIVER;
            // Both river objects go out back to back
            S_DRAW_RIVER_1:    next_state = scan_done ? S_DRAW_RIVER_2 : S_DRAW_RIVER_1;
            S_DRAW_RIVER_2:    next_state = scan_done ? S_WAIT_FROG : S_DRAW_RIVER_2;
            S_WAIT_FROG:       next_state = go ? S_DRAW_FROG : S_WAIT_FROG;
            // Game loop restarts from the background
            S_DRAW_FROG:       next_state = scan_done ? S_DRAW_BACKGROUND : S_DRAW_FROG;
            default:           next_state = S_WAIT_START;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_WAIT_START;
        end else begin
            state <= next_state;
        end
    end

    // One strobe per draw state
    always_comb begin
        draw_start      = (state == S_DRAW_START);
        draw_game_over  = (state == S_DRAW_GAME_OVER);
        draw_background = (state == S_DRAW_BACKGROUND);
        draw_river_1    = (state == S_DRAW_RIVER_1);
        draw_river_2    = (state == S_DRAW_RIVER_2);
        draw_frog       = (state == S_DRAW_FROG);
    end

endmodule

`default_nettype wire

/* raster_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_scan import frogger_pkg::*; #(
    parameter int SCAN_W = 8,
    parameter int SCAN_H = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    output logic [COORD_W-1:0] col,
    output logic [COORD_W-1:0] row,
    output logic               done
);

    localparam logic [COORD_W-1:0] LAST_COL = COORD_W'(SCAN_W - 1);
    localparam logic [COORD_W-1:0] LAST_ROW = COORD_W'(SCAN_H - 1);

    logic at_last_col;

    assign at_last_col = (col == LAST_COL);
    assign done        = enable && at_last_col && (row == LAST_ROW);

    // x inner, y outer; idle scanner parks at 0,0
    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            col <= '0;
            row <= '0;
        end else if (done) begin
            col <= '0;
            row <= '0;
        end else if (at_last_col) begin
            col <= '0;
            row <= row + 1'b1;
        end else begin
            col <= col + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* sprite_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_rom import frogger_pkg::*; (
    input  logic               clk,
    input  logic [1:0]         sprite,
    input  logic [2:0]         row,
    input  logic [2:0]         col,
    output logic [COLOR_W-1:0] pixel
);

    pixel_row_u mem [SPRITE_ROWS];

    pixel_row_u row_q;
    logic [2:0] col_q;

    initial begin
        $readmemh(SPRITE_FILE, mem);
    end

    // Row address is sprite index followed by the row inside the tile
    always_ff @(posedge clk) begin
        row_q <= mem[{sprite, row}];
        col_q <= col;
    end

    // Pick the pixel from the registered row
    assign pixel = row_q.pixels[col_q];

endmodule

`default_nettype wire

/* frog_position.sv */
`timescale 1ns/1ps
`default_nettype none

module frog_position import frogger_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               update,
    input  logic               left,
    input  logic               right,
    input  logic               up,
    input  logic               down,
    output logic [COORD_W-1:0] frog_x,
    output logic [COORD_W-1:0] frog_y
);

    logic step_right;
    logic step_left;
    logic step_down;
    logic step_up;

    // Opposite keys together cancel, edge steps are refused
    assign step_right = right && !left && (frog_x < FROG_X_MAX);
    assign step_left  = left && !right && (frog_x != '0);
    assign step_down  = down && !up && (frog_y < FROG_Y_MAX);
    assign step_up    = up && !down && (frog_y != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            frog_x <= '0;
            frog_y <= '0;
        end else if (update) begin
            if (step_right) begin
                frog_x <= frog_x + 1'b1;
            end else if (step_left) begin
                frog_x <= frog_x - 1'b1;
            end
            if (step_down) begin
                frog_y <= frog_y + 1'b1;
            end else if (step_up) begin
                frog_y <= frog_y - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* draw_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module draw_datapath import frogger_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               draw_start,
    input  logic               draw_game_over,
    input  logic               draw_background,
    input  logic               draw_river_1,
    input  logic               draw_river_2,
    input  logic               draw_frog,
    input  logic               left,
    input  logic               right,
    input  logic               up,
    input  logic               down,
    output logic               scan_done,
    output logic               plot,
    output logic [COORD_W-1:0] x,
    output logic [COORD_W-1:0] y,
    output logic [COLOR_W-1:0] color
);

    logic               draw_screen;
    logic               draw_river;
    logic [COORD_W-1:0] screen_col, screen_row;
    logic [COORD_W-1:0] river_col, river_row;
    logic [COORD_W-1:0] frog_col, frog_row;
    logic               screen_done, river_done, frog_done;
    logic [COORD_W-1:0] frog_x, frog_y;
    logic [1:0]         sprite;
    logic [2:0]         sprite_row, sprite_col;
    logic [COLOR_W-1:0] sprite_pixel;
    logic [COORD_W-1:0] next_x, next_y;
    logic [COLOR_W-1:0] fill_color, fill_q;
    logic               use_sprite_q;

    assign draw_screen = draw_start || draw_game_over || draw_background;
    assign draw_river  = draw_river_1 || draw_river_2;
    assign scan_done   = screen_done || river_done || frog_done;

    raster_scan #(.SCAN_W(SCREEN_W), .SCAN_H(SCREEN_H)) u_screen_scan (
        .clk(clk), .reset(reset), .enable(draw_screen),
        .col(screen_col), .row(screen_row), .done(screen_done)
    );

    raster_scan #(.SCAN_W(RIVER_W), .SCAN_H(RIVER_H)) u_river_scan (
        .clk(clk), .reset(reset), .enable(draw_river),
        .col(river_col), .row(river_row), .done(river_done)
    );

    raster_scan #(.SCAN_W(FROG_SIZE), .SCAN_H(FROG_SIZE)) u_frog_scan (
        .clk(clk), .reset(reset), .enable(draw_frog),
        .col(frog_col), .row(frog_row), .done(frog_done)
    );

    // Frog moves once its draw completes
    frog_position u_frog_pos (
        .clk(clk), .reset(reset), .update(frog_done),
        .left(left), .right(right), .up(up), .down(down),
        .frog_x(frog_x), .frog_y(frog_y)
    );

    // Frog pixels are doubled, river tiles repeat every 8 pixels
    assign sprite     = draw_frog ? SPRITE_FROG : (draw_river_2 ? SPRITE_RIVER_2 : SPRITE_RIVER_1);
    assign sprite_row = draw_frog ? frog_row[3:1] : river_row[2:0];
    assign sprite_col = draw_frog ? frog_col[3:1] : river_col[2:0];

    sprite_rom u_rom (
        .clk(clk), .sprite(sprite), .row(sprite_row), .col(sprite_col),
        .pixel(sprite_pixel)
    );

    // Screen position of the current scan coordinate
    always_comb begin
        if (draw_frog) begin
            next_x = frog_x + frog_col;
            next_y = frog_y + frog_row;
        end else if (draw_river_1) begin
            next_x = RIVER_1_X + river_col;
            next_y = RIVER_1_Y + river_row;
        end else if (draw_river_2) begin
            next_x = RIVER_2_X + river_col;
            next_y = RIVER_2_Y + river_row;
        end else begin
            next_x = screen_col;
            next_y = screen_row;
        end
    end

    assign fill_color = draw_start ? COLOR_START :
                        (draw_game_over ? COLOR_GAME_OVER : COLOR_BACKGROUND);

    always_ff @(posedge clk) begin
        if (reset) begin
            plot <= 1'b0;
        end else begin
            plot <= draw_screen || draw_river || draw_frog;
        end
    end

    // One stage to line up with the ROM read
    always_ff @(posedge clk) begin
        x            <= next_x;
        y            <= next_y;
        fill_q       <= fill_color;
        use_sprite_q <= draw_river || draw_frog;
    end

    assign color = use_sprite_q ? sprite_pixel : fill_q;

endmodule

`default_nettype wire

/* frogger_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frogger_top import frogger_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               go_key,
    input  logic               left,
    input  logic               right,
    input  logic               up,
    input  logic               down,
    output logic               plot,
    output logic [COORD_W-1:0] x,
    output logic [COORD_W-1:0] y,
    output logic [COLOR_W-1:0] color
);

    logic go;
    logic scan_done;
    logic draw_start, draw_game_over, draw_background;
    logic draw_river_1, draw_river_2, draw_frog;

    go_pulse u_go (
        .clk(clk), .reset(reset), .go_key(go_key), .go(go)
    );

    frogger_control u_control (
        .clk(clk), .reset(reset),
        .go(go), .scan_done(scan_done),
        .draw_start(draw_start), .draw_game_over(draw_game_over),
        .draw_background(draw_background),
        .draw_river_1(draw_river_1), .draw_river_2(draw_river_2),
        .draw_frog(draw_frog)
    );

    draw_datapath u_datapath (
        .clk(clk), .reset(reset),
        .draw_start(draw_start), .draw_game_over(draw_game_over),
        .draw_background(draw_background),
        .draw_river_1(draw_river_1), .draw_river_2(draw_river_2),
        .draw_frog(draw_frog),
        .left(left), .right(right), .up(up), .down(down),
        .scan_done(scan_done),
        .plot(plot), .x(x), .y(y), .color(color)
    );

endmodule

`default_nettype wire

/* tb_frogger.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_frogger import frogger_pkg::*; ();

    localparam int FIRST_PLOT_WAIT = 20;

    logic               clk;
    logic               reset;
    logic               go_key;
    logic               left, right, up, down;
    logic               plot;
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic [COLOR_W-1:0] color;

    logic [TILE_SIZE*COLOR_W-1:0] sprite_words [SPRITE_ROWS];
    int error_count;
    int check_count;
    int test_count;

    frogger_top u_frogger_top (
        .clk(clk), .reset(reset), .go_key(go_key),
        .left(left), .right(right), .up(up), .down(down),
        .plot(plot), .x(x), .y(y), .color(color)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Inputs change and outputs are sampled 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string reason);
        $display("Timeout at %0t: %s", $time, reason);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic check_plot(input string what, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t: %s plot is %b, expected %b",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_coord(input string what, input logic [COORD_W-1:0] actual,
                               input logic [COORD_W-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t: %s is %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_color(input string what, input logic [COLOR_W-1:0] actual,
                               input logic [COLOR_W-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t: %s color is %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    // Pixel col of a sprite row with pixel 0 in the low bits
    function automatic logic [COLOR_W-1:0] expected_sprite_color(input int index,
                                                                 input int row,
                                                                 input int col);
        logic [TILE_SIZE*COLOR_W-1:0] word;
        word = sprite_words[index*TILE_SIZE + row];
        return word[col*COLOR_W +: COLOR_W];
    endfunction

    function automatic int idle_gap();
        return 10 + ($urandom % 40);
    endfunction

    task automatic expect_idle(input string what, input int cycles);
        repeat (cycles) begin
            check_plot(what, plot, 1'b0);
            next_cycle();
        end
    endtask

    task automatic press_go();
        go_key = 1'b1;
        next_cycle();
        next_cycle();
        go_key = 1'b0;
    endtask

    task automatic hold_keys(input logic l, input logic r, input logic u, input logic d);
        left  = l;
        right = r;
        up    = u;
        down  = d;
    endtask

    // Waits for the first plot and then checks every pixel in row-major order
    task automatic collect_object(input string name, input int x0, input int y0,
                                  input int w, input int h, input bit use_sprite,
                                  input int index, input int shift,
                                  input logic [COLOR_W-1:0] fill, input int max_wait);
        int waited;
        int r;
        int c;
        logic [COLOR_W-1:0] exp_color;
        waited = 0;
        while (plot !== 1'b1) begin
            if (waited >= max_wait) begin
                abort_run({"first plot of ", name, " did not arrive in time"});
            end
            waited++;
            next_cycle();
        end
        for (r = 0; r < h; r++) begin
            for (c = 0; c < w; c++) begin
                if (use_sprite) begin
                    exp_color = expected_sprite_color(index, (r >> shift) % TILE_SIZE,
                                                      (c >> shift) % TILE_SIZE);
                end else begin
                    exp_color = fill;
                end
                check_plot(name, plot, 1'b1);
                check_coord({name, " x"}, x, COORD_W'(x0 + c));
                check_coord({name, " y"}, y, COORD_W'(y0 + r));
                check_color(name, color, exp_color);
                next_cycle();
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("Test %-20s %s (%0d errors)", name,
                 (error_count == errors_before) ? "ok" : "failed",
                 error_count - errors_before);
    endtask

    task automatic idle_after_reset();
        int errors_before;
        errors_before = error_count;
        expect_idle("idle after reset", idle_gap());
        report_test("idle after reset", errors_before);
    endtask

    task automatic full_screen_draw(input string name, input logic [COLOR_W-1:0] fill);
        int errors_before;
        errors_before = error_count;
        press_go();
        collect_object(name, 0, 0, SCREEN_W, SCREEN_H, 1'b0, 0, 0, fill, FIRST_PLOT_WAIT);
        expect_idle(name, idle_gap());
        report_test(name, errors_before);
    endtask

    // Key stays down well past the end of the fill
    task automatic held_go_background();
        int errors_before;
        errors_before = error_count;
        go_key = 1'b1;
        collect_object("background", 0, 0, SCREEN_W, SCREEN_H, 1'b0, 0, 0,
                       COLOR_BACKGROUND, FIRST_PLOT_WAIT);
        expect_idle("held go", idle_gap() + 40);
        go_key = 1'b0;
        next_cycle();
        expect_idle("released go", idle_gap());
        report_test("held go background", errors_before);
    endtask

    task automatic river_objects(input string name);
        int errors_before;
        errors_before = error_count;
        press_go();
        collect_object("river 1", RIVER_1_X, RIVER_1_Y, RIVER_W, RIVER_H, 1'b1,
                       SPRITE_RIVER_1, 0, '0, FIRST_PLOT_WAIT);
        collect_object("river 2", RIVER_2_X, RIVER_2_Y, RIVER_W, RIVER_H, 1'b1,
                       SPRITE_RIVER_2, 0, '0, 0);
        expect_idle("after rivers", idle_gap());
        report_test(name, errors_before);
    endtask

    // Frog at double scale with the background following at once
    task automatic frog_draw(input string name, input int fx, input int fy);
        int errors_before;
        errors_before = error_count;
        press_go();
        collect_object("frog", fx, fy, FROG_SIZE, FROG_SIZE, 1'b1, SPRITE_FROG, 1, '0,
                       FIRST_PLOT_WAIT);
        collect_object("background", 0, 0, SCREEN_W, SCREEN_H, 1'b0, 0, 0,
                       COLOR_BACKGROUND, 0);
        expect_idle("after frog", idle_gap());
        report_test(name, errors_before);
    endtask

    initial begin
        void'($urandom(83122));
        $timeformat(-9, 0, " ns", 0);
        reset       = 1'b1;
        go_key      = 1'b0;
        left        = 1'b0;
        right       = 1'b0;
        up          = 1'b0;
        down        = 1'b0;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        $readmemh(SPRITE_FILE, sprite_words);
        repeat (10) next_cycle();
        reset = 1'b0;

        idle_after_reset();
        full_screen_draw("start screen", COLOR_START);
        full_screen_draw("game over screen", COLOR_GAME_OVER);
        held_go_background();
        river_objects("river objects");
        frog_draw("frog at home", 0, 0);

        // Keys are sampled when the frog scan ends
        hold_keys(1'b0, 1'b1, 1'b0, 1'b1);
        river_objects("rivers, right down");
        frog_draw("frog before move", 0, 0);
        hold_keys(1'b1, 1'b0, 1'b1, 1'b0);
        river_objects("rivers, left up");
        frog_draw("frog moved", 1, 1);
        river_objects("rivers, left up 2");
        frog_draw("frog back home", 0, 0);
        river_objects("rivers, clamped");
        frog_draw("frog clamped", 0, 0);

        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sprites.mem */
// One 24-bit sprite row per line, eight 3-bit pixels, pixel 0 in the low bits
// Rows 0-7 frog, rows 8-15 river object 1, rows 16-23 river object 2
3A1C52
7F05B3
12D4E8
6C3391
A5F0C7
0E8B24
D27A6F
49C1BD
492492
1F3A8C
8D2E71
5B6C90
C4A317
2E95DA
70F1E3
96B845
FAC688
05A7E2
3D9C14
E17B56
681F0D
BC4327
4F2A99
D8E6B1

/* compile.f */
frogger_pkg.sv
go_pulse.sv
frogger_control.sv
raster_scan.sv
sprite_rom.sv
frog_position.sv
draw_datapath.sv
frogger_top.sv
tb_frogger.sv

/* Bender.yml */
package:
  name: frogger

sources:
  - frogger_pkg.sv
  - go_pulse.sv
  - frogger_control.sv
  - raster_scan.sv
  - sprite_rom.sv
  - frog_position.sv
  - draw_datapath.sv
  - frogger_top.sv
  - target: simulation
    files:
      - tb_frogger.sv
